// File: source/raster_cmd_pkg.sv
package raster_cmd_pkg;

    // one quad-SPI transfer
    localparam int NIBBLE_W = 4;

    typedef logic [NIBBLE_W-1:0] nibble_t;

    typedef enum logic [NIBBLE_W-1:0] {
        OP_IDLE        = 4'd0,
        OP_CREATE_VERT = 4'd1,
        OP_CREATE_TRI  = 4'd2,
        OP_CREATE_INST = 4'd3,
        OP_UPDATE_INST = 4'd4
    } opcode_e;

    // returned as the last response nibble
    typedef enum logic [NIBBLE_W-1:0] {
        ST_OK             = 4'd0,
        ST_INVALID_OPCODE = 4'd1,
        ST_OUT_OF_MEMORY  = 4'd2,
        ST_INVALID_ID     = 4'd4
    } status_e;

    typedef enum logic [2:0] {
        LOAD_OP,
        VERT_PHASE,
        TRI_PHASE,
        INST_PHASE,
        UPDATE_PHASE,
        RESPOND
    } seq_state_e;

endpackage

// File: source/raster_geom_pkg.sv
package raster_geom_pkg;

    localparam int ID_W    = 8;
    localparam int COUNT_W = 12;

    // vertex and triangle pools share one address width
    localparam int POOL_AW   = 13;
    localparam int VERT_POOL = 8192;
    localparam int TRI_POOL  = 8192;

    localparam int VTX_W   = 108;  // xyz floats plus three 4 bit attributes
    localparam int TRI_W   = 36;   // three 12 bit vertex indices
    localparam int XFORM_W = 384;  // 12 floats, position, rotation and scale

    typedef logic [ID_W-1:0]    id_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [POOL_AW-1:0] pool_addr_t;
    typedef logic [VTX_W-1:0]   vertex_t;
    typedef logic [TRI_W-1:0]   triangle_t;
    typedef logic [XFORM_W-1:0] transform_t;

endpackage

// File: source/cmd_sequencer.sv
`timescale 1ns/100ps

module cmd_sequencer (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    cs_n,
    input  raster_cmd_pkg::nibble_t spi_din,
    output logic                    vert_nib_en,
    output logic                    tri_nib_en,
    output logic                    inst_nib_en,
    output logic                    inst_mode_update,
    output logic                    abort,
    input  logic                    vert_done,
    input  logic                    tri_done,
    input  logic                    inst_done,
    input  raster_cmd_pkg::status_e vert_status,
    input  raster_cmd_pkg::status_e tri_status,
    input  raster_cmd_pkg::status_e inst_status,
    input  raster_geom_pkg::id_t    vert_id,
    input  raster_geom_pkg::id_t    tri_id,
    input  raster_geom_pkg::id_t    inst_id,
    output logic                    resp_start,
    output raster_geom_pkg::id_t    resp_id,
    output raster_cmd_pkg::status_e resp_status,
    output logic                    resp_short,
    input  logic                    resp_done
);
    import raster_cmd_pkg::*;

    seq_state_e state;
    status_e    pending;     // sticky error from a consumed opcode
    status_e    loader_status;

    assign abort            = cs_n;
    assign vert_nib_en      = !cs_n && state == VERT_PHASE;
    assign tri_nib_en       = !cs_n && state == TRI_PHASE;
    assign inst_nib_en      = !cs_n && (state == INST_PHASE || state == UPDATE_PHASE);
    assign inst_mode_update = state == UPDATE_PHASE;
    assign resp_short       = inst_mode_update;  // update answers with status only

    // result of whichever loader owns the phase
    always_comb begin
        resp_start    = 1'b0;
        resp_id       = inst_id;
        loader_status = inst_status;
        case (state)
            VERT_PHASE: begin
                resp_start    = vert_done;
                resp_id       = vert_id;
                loader_status = vert_status;
            end
            TRI_PHASE: begin
                resp_start    = tri_done;
                resp_id       = tri_id;
                loader_status = tri_status;
            end
            INST_PHASE, UPDATE_PHASE: begin
                resp_start = inst_done;
            end
            default: ;
        endcase
    end

    // own error wins over the pending one
    assign resp_status = (loader_status != ST_OK) ? loader_status : pending;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state   <= LOAD_OP;
            pending <= ST_OK;
        end else if (cs_n) begin
            state <= LOAD_OP;
        end else begin
            case (state)
                LOAD_OP: begin
                    case (opcode_e'(spi_din))
                        OP_IDLE:        ;
                        OP_CREATE_VERT: state <= VERT_PHASE;
                        OP_CREATE_TRI:  state <= TRI_PHASE;
                        OP_CREATE_INST: state <= INST_PHASE;
                        OP_UPDATE_INST: state <= UPDATE_PHASE;
                        default:        pending <= ST_INVALID_OPCODE;
                    endcase
                end
                VERT_PHASE, TRI_PHASE, INST_PHASE, UPDATE_PHASE: begin
                    if (resp_start) begin
                        state   <= RESPOND;
                        pending <= ST_OK;  // reported now
                    end
                end
                RESPOND: begin
                    if (resp_done) state <= LOAD_OP;
                end
                default: state <= LOAD_OP;
            endcase
        end
    end

endmodule

// File: source/buffer_loader.sv
`timescale 1ns/100ps

module buffer_loader #(
    parameter int ELEM_W    = raster_geom_pkg::VTX_W,
    parameter int POOL_SIZE = raster_geom_pkg::VERT_POOL
) (
    input  logic                       sck,
    input  logic                       rst,
    input  logic                       abort,
    input  logic                       nib_en,
    input  raster_cmd_pkg::nibble_t    nib,
    output logic                       done,
    output raster_cmd_pkg::status_e    status,
    output raster_geom_pkg::id_t       buf_id,
    output raster_geom_pkg::id_t       next_id,
    output logic                       hdr_valid,
    output raster_geom_pkg::pool_addr_t base,
    output raster_geom_pkg::count_t    count,
    output logic                       elem_valid,
    output logic [ELEM_W-1:0]          elem
);
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    localparam int CNT_NIBS  = COUNT_W / NIBBLE_W;
    localparam int ELEM_NIBS = ELEM_W / NIBBLE_W;
    localparam int NIB_CW    = $clog2(ELEM_NIBS > CNT_NIBS ? ELEM_NIBS : CNT_NIBS);

    logic              in_elems;  // header taken, elements follow
    logic [NIB_CW-1:0] nib_cnt;
    count_t            elem_cnt;
    logic              err;
    id_t               id_r;
    logic [POOL_AW:0]  next_base;  // one extra bit, a full pool is legal
    count_t            cnt_in;
    logic [POOL_AW:0]  end_addr;
    logic              oom_now;
    logic              hdr_last;
    logic              elem_last;

    assign cnt_in    = {count[COUNT_W-NIBBLE_W-1:0], nib};
    assign end_addr  = next_base + cnt_in;
    assign oom_now   = end_addr > POOL_SIZE;
    assign hdr_last  = nib_en && !in_elems && nib_cnt == CNT_NIBS - 1;
    assign elem_last = nib_en && in_elems && nib_cnt == ELEM_NIBS - 1;

    // empty buffer finishes on the header
    assign done   = (hdr_last && cnt_in == '0) || (elem_last && elem_cnt == count - 1'b1);
    assign status = (hdr_last ? oom_now : err) ? ST_OUT_OF_MEMORY : ST_OK;
    assign buf_id = hdr_last ? next_id : id_r;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            in_elems   <= 1'b0;
            nib_cnt    <= '0;
            elem_cnt   <= '0;
            err        <= 1'b0;
            hdr_valid  <= 1'b0;
            elem_valid <= 1'b0;
            next_id    <= '0;
            next_base  <= '0;
        end else begin
            hdr_valid  <= 1'b0;
            elem_valid <= 1'b0;
            if (abort) begin
                in_elems <= 1'b0;
                nib_cnt  <= '0;
                elem_cnt <= '0;
            end else if (hdr_last) begin
                nib_cnt   <= '0;
                elem_cnt  <= '0;
                err       <= oom_now;
                hdr_valid <= !oom_now;
                in_elems  <= cnt_in != '0;
                if (!oom_now) begin  // failed header leaves id and pool untouched
                    next_id   <= next_id + 1'b1;
                    next_base <= end_addr;
                end
            end else if (elem_last) begin
                nib_cnt    <= '0;
                elem_valid <= !err;
                if (done) in_elems <= 1'b0;
                else elem_cnt <= elem_cnt + 1'b1;
            end else if (nib_en) begin
                nib_cnt <= nib_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sck) begin
        if (nib_en && !in_elems) count <= cnt_in;
        if (nib_en && in_elems) elem <= {elem[ELEM_W-NIBBLE_W-1:0], nib};
        if (hdr_last) begin
            id_r <= next_id;
            base <= next_base[POOL_AW-1:0];
        end
    end

endmodule

// File: source/instance_loader.sv
`timescale 1ns/100ps

module instance_loader (
    input  logic                       sck,
    input  logic                       rst,
    input  logic                       abort,
    input  logic                       nib_en,
    input  raster_cmd_pkg::nibble_t    nib,
    input  logic                       mode_update,
    input  raster_geom_pkg::id_t       vert_next_id,
    input  raster_geom_pkg::id_t       tri_next_id,
    output logic                       done,
    output raster_cmd_pkg::status_e    status,
    output logic                       inst_valid,
    output logic                       inst_update,
    output raster_geom_pkg::id_t       inst_id,
    output raster_geom_pkg::id_t       inst_vert_id,
    output raster_geom_pkg::id_t       inst_tri_id,
    output raster_geom_pkg::transform_t inst_transform
);
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    localparam int ID_NIBS = ID_W / NIBBLE_W;
    localparam int XF_NIBS = XFORM_W / NIBBLE_W;

    logic              in_xform;
    logic [6:0]        nib_cnt;   // up to 96 transform nibbles
    logic              err;
    id_t               next_inst;
    logic [2*ID_W-1:0] id_sr;
    logic [2*ID_W-1:0] id_in;
    logic              id_last;
    logic              xform_last;
    logic              bad_id;

    assign id_in      = {id_sr[2*ID_W-NIBBLE_W-1:0], nib};
    assign id_last    = nib_en && !in_xform &&
                        nib_cnt == (mode_update ? ID_NIBS - 1 : 2 * ID_NIBS - 1);
    assign xform_last = nib_en && in_xform && nib_cnt == XF_NIBS - 1;

    // create checks both buffer ids, update the instance id
    always_comb begin
        if (mode_update)
            bad_id = id_in[ID_W-1:0] == '0 || id_in[ID_W-1:0] >= next_inst;
        else
            bad_id = id_in[2*ID_W-1:ID_W] >= vert_next_id || id_in[ID_W-1:0] >= tri_next_id;
    end

    assign done   = xform_last;
    assign status = err ? ST_INVALID_ID : ST_OK;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            in_xform    <= 1'b0;
            nib_cnt     <= '0;
            err         <= 1'b0;
            next_inst   <= 8'd1;  // 0 is the camera
            inst_valid  <= 1'b0;
            inst_update <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            if (abort) begin
                in_xform <= 1'b0;
                nib_cnt  <= '0;
            end else if (id_last) begin
                nib_cnt  <= '0;
                in_xform <= 1'b1;
                err      <= bad_id;
                if (!mode_update && !bad_id) next_inst <= next_inst + 1'b1;
            end else if (xform_last) begin
                nib_cnt     <= '0;
                in_xform    <= 1'b0;
                inst_valid  <= !err;
                inst_update <= mode_update;
            end else if (nib_en) begin
                nib_cnt <= nib_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sck) begin
        if (nib_en && !in_xform) id_sr <= id_in;
        if (id_last && mode_update) inst_id <= id_in[ID_W-1:0];
        if (id_last && !mode_update) begin
            inst_id      <= next_inst;  // unconsumed id on error
            inst_vert_id <= id_in[2*ID_W-1:ID_W];
            inst_tri_id  <= id_in[ID_W-1:0];
        end
        if (nib_en && in_xform) inst_transform <= {inst_transform[XFORM_W-NIBBLE_W-1:0], nib};
    end

endmodule

// File: source/response_shifter.sv
`timescale 1ns/100ps

module response_shifter (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    resp_start,
    input  raster_geom_pkg::id_t    resp_id,
    input  raster_cmd_pkg::status_e resp_status,
    input  logic                    resp_short,
    output raster_cmd_pkg::nibble_t spi_dout,
    output logic                    spi_oe,
    output logic                    resp_done
);
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    id_t        id_r;
    status_e    status_r;
    logic [1:0] slot;  // 0 id high, 1 id low, 2 status

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            spi_oe <= 1'b0;
            slot   <= '0;
        end else if (resp_start) begin
            spi_oe <= 1'b1;
            slot   <= resp_short ? 2'd2 : 2'd0;
        end else if (spi_oe) begin
            if (slot == 2'd2) spi_oe <= 1'b0;
            else slot <= slot + 1'b1;
        end
    end

    always_ff @(posedge sck) begin
        if (resp_start) begin
            id_r     <= resp_id;
            status_r <= resp_status;
        end
    end

    always_comb begin
        case (slot)
            2'd0:    spi_dout = id_r[ID_W-1:NIBBLE_W];
            2'd1:    spi_dout = id_r[NIBBLE_W-1:0];
            default: spi_dout = status_r;
        endcase
    end

    assign resp_done = spi_oe && slot == 2'd2;

endmodule

// File: source/spi_cmd_port.sv
`timescale 1ns/100ps

module spi_cmd_port (
    input  logic                        sck,
    input  logic                        rst,
    input  logic                        cs_n,
    input  raster_cmd_pkg::nibble_t     spi_din,
    output raster_cmd_pkg::nibble_t     spi_dout,
    output logic                        spi_oe,
    output logic                        vert_hdr_valid,
    output raster_geom_pkg::id_t        vert_buf_id,
    output raster_geom_pkg::pool_addr_t vert_base,
    output raster_geom_pkg::count_t     vert_count,
    output logic                        vert_valid,
    output raster_geom_pkg::vertex_t    vert_data,
    output logic                        tri_hdr_valid,
    output raster_geom_pkg::id_t        tri_buf_id,
    output raster_geom_pkg::pool_addr_t tri_base,
    output raster_geom_pkg::count_t     tri_count,
    output logic                        tri_valid,
    output raster_geom_pkg::triangle_t  tri_data,
    output logic                        inst_valid,
    output logic                        inst_update,
    output raster_geom_pkg::id_t        inst_id,
    output raster_geom_pkg::id_t        inst_vert_id,
    output raster_geom_pkg::id_t        inst_tri_id,
    output raster_geom_pkg::transform_t inst_transform
);
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    logic    vert_nib_en, tri_nib_en, inst_nib_en;
    logic    inst_mode_update, abort;
    logic    vert_done, tri_done, inst_done;
    status_e vert_status, tri_status, inst_status;
    id_t     vert_next_id, tri_next_id;
    logic    resp_start, resp_short, resp_done;
    id_t     resp_id;
    status_e resp_status;

    cmd_sequencer i_cmd_sequencer (
        .sck, .rst, .cs_n, .spi_din,
        .vert_nib_en, .tri_nib_en, .inst_nib_en, .inst_mode_update, .abort,
        .vert_done, .tri_done, .inst_done,
        .vert_status, .tri_status, .inst_status,
        .vert_id (vert_buf_id),
        .tri_id  (tri_buf_id),
        .inst_id,
        .resp_start, .resp_id, .resp_status, .resp_short, .resp_done
    );

    buffer_loader #(.ELEM_W(VTX_W), .POOL_SIZE(VERT_POOL)) vert_loader (
        .sck, .rst, .abort,
        .nib_en     (vert_nib_en),
        .nib        (spi_din),
        .done       (vert_done),
        .status     (vert_status),
        .buf_id     (vert_buf_id),
        .next_id    (vert_next_id),
        .hdr_valid  (vert_hdr_valid),
        .base       (vert_base),
        .count      (vert_count),
        .elem_valid (vert_valid),
        .elem       (vert_data)
    );

    buffer_loader #(.ELEM_W(TRI_W), .POOL_SIZE(TRI_POOL)) tri_loader (
        .sck, .rst, .abort,
        .nib_en     (tri_nib_en),
        .nib        (spi_din),
        .done       (tri_done),
        .status     (tri_status),
        .buf_id     (tri_buf_id),
        .next_id    (tri_next_id),
        .hdr_valid  (tri_hdr_valid),
        .base       (tri_base),
        .count      (tri_count),
        .elem_valid (tri_valid),
        .elem       (tri_data)
    );

    instance_loader i_instance_loader (
        .sck, .rst, .abort,
        .nib_en      (inst_nib_en),
        .nib         (spi_din),
        .mode_update (inst_mode_update),
        .vert_next_id, .tri_next_id,
        .done        (inst_done),
        .status      (inst_status),
        .inst_valid, .inst_update, .inst_id, .inst_vert_id, .inst_tri_id, .inst_transform
    );

    response_shifter i_response_shifter (
        .sck, .rst, .resp_start, .resp_id, .resp_status, .resp_short,
        .spi_dout, .spi_oe, .resp_done
    );

endmodule

// File: bench/spi_cmd_port_assertions.sv
`timescale 1ns/100ps

module spi_cmd_port_assertions (
    input logic sck,
    input logic rst,
    input logic cs_n,
    input logic spi_oe,
    input logic vert_hdr_valid,
    input logic vert_valid,
    input logic tri_hdr_valid,
    input logic tri_valid,
    input logic inst_valid
);

    int fail_count = 0;

    property one_cycle(sig);
        @(posedge sck) disable iff (rst) sig |=> !sig;
    endproperty

    // pad only driven while selected
    oe_needs_cs: assert property (@(posedge sck) disable iff (rst) cs_n |-> !spi_oe)
        else begin
            $error("spi_oe high while cs_n is high");
            fail_count++;
        end

    vert_hdr_pulse: assert property (one_cycle(vert_hdr_valid))
        else begin
            $error("vert_hdr_valid held longer than one cycle");
            fail_count++;
        end
    vert_pulse: assert property (one_cycle(vert_valid))
        else begin
            $error("vert_valid held longer than one cycle");
            fail_count++;
        end
    tri_hdr_pulse: assert property (one_cycle(tri_hdr_valid))
        else begin
            $error("tri_hdr_valid held longer than one cycle");
            fail_count++;
        end
    tri_pulse: assert property (one_cycle(tri_valid))
        else begin
            $error("tri_valid held longer than one cycle");
            fail_count++;
        end
    inst_pulse: assert property (one_cycle(inst_valid))
        else begin
            $error("inst_valid held longer than one cycle");
            fail_count++;
        end

    one_buffer_kind: assert property (@(posedge sck) disable iff (rst) !(vert_valid && tri_valid))
        else begin
            $error("vert_valid and tri_valid high together");
            fail_count++;
        end

endmodule

bind spi_cmd_port spi_cmd_port_assertions i_spi_cmd_port_assertions (.*);

// File: bench/spi_cmd_port_tb.sv
`timescale 1ns/100ps

module spi_cmd_port_tb;
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    // arg is the count, the vertex buffer id or the instance id
    typedef struct packed {
        logic [3:0] op;
        count_t     arg;
        id_t        tri_arg;
        id_t        exp_id;
        status_e    exp_st;
    } row_t;

    localparam int N_ROWS = 12;
    localparam int INST_W = 1 + 3 * ID_W + XFORM_W;

    row_t rows [N_ROWS] = '{
        '{OP_CREATE_VERT, 12'd3,    8'd0, 8'd0, ST_OK},
        '{OP_CREATE_TRI,  12'd4095, 8'd0, 8'd0, ST_OK},
        '{OP_CREATE_TRI,  12'd4095, 8'd0, 8'd1, ST_OK},
        '{OP_CREATE_TRI,  12'd3,    8'd0, 8'd2, ST_OUT_OF_MEMORY},  // pool full
        '{OP_CREATE_TRI,  12'd2,    8'd0, 8'd2, ST_OK},
        '{OP_CREATE_INST, 12'd0,    8'd1, 8'd1, ST_OK},
        '{OP_CREATE_INST, 12'd0,    8'd2, 8'd2, ST_OK},
        '{OP_CREATE_INST, 12'd5,    8'd0, 8'd3, ST_INVALID_ID},
        '{OP_UPDATE_INST, 12'd1,    8'd0, 8'd1, ST_OK},
        '{4'hf,           12'd0,    8'd0, 8'd0, ST_OK},
        '{OP_UPDATE_INST, 12'd2,    8'd0, 8'd2, ST_INVALID_OPCODE},
        '{OP_CREATE_VERT, 12'd0,    8'd0, 8'd1, ST_OK}
    };

    logic        sck, rst, cs_n, spi_oe;
    nibble_t     spi_din, spi_dout;
    logic        vert_hdr_valid, vert_valid, tri_hdr_valid, tri_valid;
    logic        inst_valid, inst_update;
    id_t         vert_buf_id, tri_buf_id, inst_id, inst_vert_id, inst_tri_id;
    pool_addr_t  vert_base, tri_base;
    count_t      vert_count, tri_count;
    vertex_t     vert_data;
    triangle_t   tri_data;
    transform_t  inst_transform;

    integer              seed = 32'ha8ac7e3f;
    logic [32:0]         hdr_q[$];  // id, base, count
    vertex_t             got_elems[$];
    vertex_t             exp_elems[$];
    logic [INST_W-1:0]   inst_q[$];
    int                  vert_used = 0;
    int                  tri_used = 0;

    spi_cmd_port i_spi_cmd_port (.*);

    initial begin
        sck = 1'b0;
        forever #50 sck = ~sck;
    end

    always @(negedge sck) begin
        if (vert_hdr_valid) hdr_q.push_back({vert_buf_id, vert_base, vert_count});
        if (tri_hdr_valid) hdr_q.push_back({tri_buf_id, tri_base, tri_count});
        if (vert_valid) got_elems.push_back(vert_data);
        if (tri_valid) got_elems.push_back(vertex_t'(tri_data));
        if (inst_valid)
            inst_q.push_back({inst_update, inst_id, inst_vert_id, inst_tri_id, inst_transform});
    end

    task automatic report_mismatch(input string name, input logic [INST_W-1:0] got,
                                   input logic [INST_W-1:0] exp);
        $display("[FAIL] %s got 'h%0h expected 'h%0h", name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    always @(i_spi_cmd_port.i_spi_cmd_port_assertions.fail_count)
        assert (i_spi_cmd_port.i_spi_cmd_port_assertions.fail_count == 0)
            else stop_on_error("a protocol assertion on spi_cmd_port failed");

    // msb nibble first on consecutive edges
    task automatic send_nibs(input transform_t v, input int nibs);
        for (int i = nibs - 1; i >= 0; i--) begin
            spi_din <= v[i*NIBBLE_W +: NIBBLE_W];
            @(posedge sck);
        end
    endtask

    function automatic transform_t rand_bits(input int width);
        transform_t v;
        for (int i = 0; i < XFORM_W / 32; i++)
            v = {v[XFORM_W-33:0], $random(seed)};
        return v & ((transform_t'(1) << width) - 1'b1);
    endfunction

    task automatic read_response(output int n, output logic [11:0] r);
        int t;
        n = 0;
        r = '0;
        t = 0;
        do begin
            @(negedge sck);
            t++;
        end while (!spi_oe && t < 8);
        assert (spi_oe) else stop_on_error("timeout waiting for spi_oe after a command");
        while (spi_oe && n < 4) begin
            r = {r[7:0], spi_dout};
            n++;
            @(negedge sck);
        end
    endtask

    initial begin
        row_t              c;
        transform_t        v;
        logic [INST_W-1:0] got_inst, exp_inst;
        logic [11:0]       resp, exp_resp;
        logic [32:0]       exp_hdr;
        int                nresp, exp_n, ew, exp_hdrs;
        logic              own_ok, is_buf;
        string             dname;

        rst = 1'b1;
        cs_n = 1'b1;
        spi_din = '0;
        repeat (8) @(posedge sck);
        rst <= 1'b0;
        cs_n <= 1'b0;

        // triangle header cut short by chip select
        @(posedge sck);
        spi_din <= OP_CREATE_TRI;
        @(posedge sck);
        send_nibs(12'hfff, 2);
        spi_din <= '0;
        cs_n <= 1'b1;
        repeat (2) @(posedge sck);
        cs_n <= 1'b0;

        for (int k = 0; k < N_ROWS; k++) begin
            c = rows[k];
            own_ok = c.exp_st != ST_OUT_OF_MEMORY && c.exp_st != ST_INVALID_ID;
            is_buf = c.op == OP_CREATE_VERT || c.op == OP_CREATE_TRI;
            exp_n = (c.op == OP_UPDATE_INST) ? 1 : (c.op >= 4'd1 && c.op <= 4'd3) ? 3 : 0;
            ew = (c.op == OP_CREATE_VERT) ? VTX_W : TRI_W;
            dname = (c.op == OP_CREATE_VERT) ? "vert_data" : "tri_data";
            @(posedge sck);
            spi_din <= c.op;
            @(posedge sck);
            if (is_buf) begin
                send_nibs(c.arg, COUNT_W / NIBBLE_W);
                for (int e = 0; e < c.arg; e++) begin
                    v = rand_bits(ew);
                    if (own_ok) exp_elems.push_back(vertex_t'(v));
                    send_nibs(v, ew / NIBBLE_W);
                end
            end else if (exp_n != 0) begin
                if (c.op == OP_CREATE_INST) send_nibs({c.arg[7:0], c.tri_arg}, 4);
                else send_nibs(c.arg[7:0], 2);
                v = rand_bits(XFORM_W);
                exp_inst = {c.op == OP_UPDATE_INST, c.exp_id, c.arg[7:0], c.tri_arg, v};
                send_nibs(v, XFORM_W / NIBBLE_W);
            end
            spi_din <= '0;

            if (exp_n == 0) begin
                repeat (6) begin
                    @(negedge sck);
                    assert (!spi_oe) else stop_on_error("response to an opcode that takes none");
                end
            end else begin
                read_response(nresp, resp);
                assert (nresp == exp_n) else report_mismatch("spi_oe cycles", nresp, exp_n);
                exp_resp = (exp_n == 3) ? {c.exp_id, c.exp_st} : 12'(c.exp_st);
                assert (resp == exp_resp) else report_mismatch("spi_dout", resp, exp_resp);
            end

            exp_hdrs = (is_buf && own_ok) ? 1 : 0;
            assert (hdr_q.size() == exp_hdrs)
                else report_mismatch("hdr_valid", hdr_q.size(), exp_hdrs);
            if (exp_hdrs == 1) begin
                ew = (c.op == OP_CREATE_VERT) ? vert_used : tri_used;
                exp_hdr = {c.exp_id, pool_addr_t'(ew), c.arg};
                assert (hdr_q[0] == exp_hdr)
                    else report_mismatch("buf_id base count", hdr_q[0], exp_hdr);
                if (c.op == OP_CREATE_VERT) vert_used += c.arg;
                else tri_used += c.arg;
                void'(hdr_q.pop_front());
            end

            assert (got_elems.size() == exp_elems.size())
                else report_mismatch({dname, " strobes"}, got_elems.size(), exp_elems.size());
            for (int i = 0; i < exp_elems.size(); i++)
                assert (got_elems[i] == exp_elems[i])
                    else report_mismatch(dname, got_elems[i], exp_elems[i]);
            got_elems.delete();
            exp_elems.delete();

            exp_hdrs = (!is_buf && exp_n != 0 && own_ok) ? 1 : 0;
            assert (inst_q.size() == exp_hdrs)
                else report_mismatch("inst_valid", inst_q.size(), exp_hdrs);
            if (exp_hdrs == 1) begin
                got_inst = inst_q.pop_front();
                // buffer ids are not part of an update
                if (c.op == OP_UPDATE_INST) begin
                    got_inst[XFORM_W +: 2*ID_W] = '0;
                    exp_inst[XFORM_W +: 2*ID_W] = '0;
                end
                assert (got_inst == exp_inst)
                    else report_mismatch("inst outputs", got_inst, exp_inst);
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: flist.f
source/raster_cmd_pkg.sv
source/raster_geom_pkg.sv
source/cmd_sequencer.sv
source/buffer_loader.sv
source/instance_loader.sv
source/response_shifter.sv
source/spi_cmd_port.sv
bench/spi_cmd_port_assertions.sv
bench/spi_cmd_port_tb.sv

// File: Bender.yml
package:
  name: spi_cmd_port

sources:
  - source/raster_cmd_pkg.sv
  - source/raster_geom_pkg.sv
  - source/cmd_sequencer.sv
  - source/buffer_loader.sv
  - source/instance_loader.sv
  - source/response_shifter.sv
  - source/spi_cmd_port.sv
  - target: test
    files:
      - bench/spi_cmd_port_assertions.sv
      - bench/spi_cmd_port_tb.sv
